// ==== src/mem_refill_pkg.sv ====
`default_nettype none

package mem_refill_pkg;

    // memory side geometry
    localparam int ADDR_BITS        = 32;
    localparam int BEAT_BITS        = 64;
    localparam int BEATS_PER_LINE   = 4;
    localparam int LINE_BITS        = BEAT_BITS * BEATS_PER_LINE; // 256
    localparam int LINE_OFFSET_BITS = 5;  // 32 bytes per line

    localparam int BEAT_IDX_BITS    = $clog2(BEATS_PER_LINE);

    // byte address
    typedef logic [ADDR_BITS-1:0] addr_t;

    // one bus beat
    typedef logic [BEAT_BITS-1:0] beat_t;

    // full cache line, beat 0 sits in the low bits
    typedef logic [LINE_BITS-1:0] line_t;

    typedef logic [BEAT_IDX_BITS-1:0] beat_idx_t;

    // refill arbiter FSM
    typedef enum logic [2:0] {
        ARB_IDLE,       // waiting for a request
        ARB_READ_REQ,   // bmem_read held until ready
        ARB_READ_WAIT,  // beats coming back
        ARB_WRITE,      // serializer busy
        ARB_ACK         // ack high until req drops
    } arb_state_t;

endpackage : mem_refill_pkg

`default_nettype wire

// ==== src/line_xfer_if.sv ====
`default_nettype none

interface line_xfer_if;
    import mem_refill_pkg::*;

    logic  start;  // one cycle kick from the arbiter
    line_t wline;  // line to send, serializer only
    line_t rline;  // line held by the engine
    logic  done;   // one cycle completion pulse

    // arbiter side
    modport master (
        output start,
        output wline,
        input  rline,
        input  done
    );

    // burst engine side
    modport engine (
        input  start,
        input  wline,
        output rline,
        output done
    );

endinterface : line_xfer_if

`default_nettype wire

// ==== src/burst_assembler.sv ====
`default_nettype none

module burst_assembler (
    input  logic                  clk,
    input  logic                  rst,

    input  mem_refill_pkg::beat_t bmem_rdata_i,
    input  logic                  bmem_rvalid_i,

    line_xfer_if.engine           xfer
);
    import mem_refill_pkg::*;

    logic      busy_q;   // expecting beats
    beat_idx_t cnt_q;    // next slot to fill
    logic      done_q;
    line_t     line_q;   // assembled line

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (xfer.start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q && bmem_rvalid_i) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == beat_idx_t'(BEATS_PER_LINE - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;  // line complete next cycle
                end
            end
        end
    end

    // beat lands in the slot picked by the counter
    always_ff @(posedge clk) begin
        if (busy_q && bmem_rvalid_i) begin
            line_q[cnt_q*BEAT_BITS +: BEAT_BITS] <= bmem_rdata_i;
        end
    end

    assign xfer.rline = line_q;
    assign xfer.done  = done_q;

    // memory must only return data for a read the arbiter started
    a_no_stray_rvalid: assert property (
        @(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> busy_q
    ) else $error("rvalid while assembler idle");

endmodule : burst_assembler

`default_nettype wire

// ==== src/burst_serializer.sv ====
`default_nettype none

module burst_serializer (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  bmem_ready_i,
    output logic                  bmem_write_o,
    output mem_refill_pkg::beat_t bmem_wdata_o,

    line_xfer_if.engine           xfer
);
    import mem_refill_pkg::*;

    logic      active_q;  // beats still to send
    beat_idx_t cnt_q;     // current beat
    logic      done_q;
    line_t     line_q;    // copy of the line being written

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q <= 1'b0;
            cnt_q    <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (xfer.start) begin
                active_q <= 1'b1;
                cnt_q    <= '0;
            end else if (active_q && bmem_ready_i) begin
                // beat accepted
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == beat_idx_t'(BEATS_PER_LINE - 1)) begin
                    active_q <= 1'b0;
                    done_q   <= 1'b1;
                end
            end
        end
    end

    // line held for the whole burst
    always_ff @(posedge clk) begin
        if (xfer.start) begin
            line_q <= xfer.wline;
        end
    end

    assign bmem_write_o = active_q;
    assign bmem_wdata_o = line_q[cnt_q*BEAT_BITS +: BEAT_BITS];

    // echo of the written line back to the arbiter
    assign xfer.rline = line_q;
    assign xfer.done  = done_q;

    // stalled beat must not change under the memory
    a_wdata_held: assert property (
        @(posedge clk) disable iff (rst)
        (bmem_write_o && !bmem_ready_i) |=> (bmem_write_o && $stable(bmem_wdata_o))
    ) else $error("write beat changed while stalled");

endmodule : burst_serializer

`default_nettype wire

// ==== src/refill_arbiter.sv ====
`default_nettype none

module refill_arbiter (
    input  logic                  clk,
    input  logic                  rst,

    // instruction side
    input  logic                  i_req_i,
    input  mem_refill_pkg::addr_t i_addr_i,
    output logic                  i_ack_o,
    output mem_refill_pkg::line_t i_line_o,

    // data side
    input  logic                  d_req_i,
    input  logic                  d_we_i,
    input  mem_refill_pkg::addr_t d_addr_i,
    input  mem_refill_pkg::line_t d_wline_i,
    output logic                  d_ack_o,
    output mem_refill_pkg::line_t d_line_o,

    // burst memory, read request side
    output mem_refill_pkg::addr_t bmem_addr_o,
    output logic                  bmem_read_o,
    input  logic                  bmem_ready_i,

    line_xfer_if.master           rd_xfer,
    line_xfer_if.master           wr_xfer
);
    import mem_refill_pkg::*;

    arb_state_t state_q;
    logic       grant_d_q;   // 1 = data port owns the grant
    logic       rd_start_q;
    logic       wr_start_q;
    logic       i_ack_q;
    logic       d_ack_q;

    // request payload
    addr_t      addr_q;      // aligned line address
    line_t      wline_q;
    line_t      i_line_q;
    line_t      d_line_q;

    logic       granted_req;

    function automatic addr_t line_align(input addr_t a);
        line_align = {a[ADDR_BITS-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
    endfunction

    assign granted_req = grant_d_q ? d_req_i : i_req_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ARB_IDLE;
            grant_d_q  <= 1'b0;
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
            i_ack_q    <= 1'b0;
            d_ack_q    <= 1'b0;
        end else begin
            rd_start_q <= 1'b0;
            wr_start_q <= 1'b0;
            unique case (state_q)
                ARB_IDLE: begin
                    if (d_req_i) begin
                        // data side has priority
                        grant_d_q <= 1'b1;
                        if (d_we_i) begin
                            wr_start_q <= 1'b1;
                            state_q    <= ARB_WRITE;
                        end else begin
                            rd_start_q <= 1'b1;
                            state_q    <= ARB_READ_REQ;
                        end
                    end else if (i_req_i) begin
                        grant_d_q  <= 1'b0;
                        rd_start_q <= 1'b1;
                        state_q    <= ARB_READ_REQ;
                    end
                end
                ARB_READ_REQ: begin
                    if (bmem_ready_i) begin
                        state_q <= ARB_READ_WAIT;  // read accepted
                    end
                end
                ARB_READ_WAIT: begin
                    if (rd_xfer.done) begin
                        state_q <= ARB_ACK;
                        i_ack_q <= !grant_d_q;
                        d_ack_q <= grant_d_q;
                    end
                end
                ARB_WRITE: begin
                    if (wr_xfer.done) begin
                        state_q <= ARB_ACK;
                        d_ack_q <= 1'b1;
                    end
                end
                ARB_ACK: begin
                    // hold ack until the owner lets go of req
                    if (!granted_req) begin
                        state_q <= ARB_IDLE;
                        i_ack_q <= 1'b0;
                        d_ack_q <= 1'b0;
                    end
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // address and write line picked up at grant time
    always_ff @(posedge clk) begin
        if (state_q == ARB_IDLE) begin
            if (d_req_i) begin
                addr_q  <= line_align(d_addr_i);
                wline_q <= d_wline_i;
            end else if (i_req_i) begin
                addr_q  <= line_align(i_addr_i);
            end
        end
    end

    // route the finished line to the granted port
    always_ff @(posedge clk) begin
        if (state_q == ARB_READ_WAIT && rd_xfer.done) begin
            if (grant_d_q) begin
                d_line_q <= rd_xfer.rline;
            end else begin
                i_line_q <= rd_xfer.rline;
            end
        end else if (state_q == ARB_WRITE && wr_xfer.done) begin
            d_line_q <= wr_xfer.rline;  // written line shows on d_line
        end
    end

    assign bmem_addr_o   = addr_q;
    assign bmem_read_o   = (state_q == ARB_READ_REQ);

    assign rd_xfer.start = rd_start_q;
    assign rd_xfer.wline = '0;          // assembler has no use for it
    assign wr_xfer.start = wr_start_q;
    assign wr_xfer.wline = wline_q;

    assign i_ack_o  = i_ack_q;
    assign d_ack_o  = d_ack_q;
    assign i_line_o = i_line_q;
    assign d_line_o = d_line_q;

    a_one_ack: assert property (
        @(posedge clk) disable iff (rst)
        !(i_ack_o && d_ack_o)
    ) else $error("both acks high");

    // stalled read keeps its request and its line address
    a_read_held: assert property (
        @(posedge clk) disable iff (rst)
        (bmem_read_o && !bmem_ready_i) |=> (bmem_read_o && $stable(bmem_addr_o))
    ) else $error("bmem_read dropped or moved before accept");

endmodule : refill_arbiter

`default_nettype wire

// ==== src/mem_refill_top.sv ====
`default_nettype none

module mem_refill_top (
    input  logic                  clk,
    input  logic                  rst,

    // instruction cache port
    input  logic                  i_req_i,
    input  mem_refill_pkg::addr_t i_addr_i,
    output logic                  i_ack_o,
    output mem_refill_pkg::line_t i_line_o,

    // data cache port
    input  logic                  d_req_i,
    input  logic                  d_we_i,
    input  mem_refill_pkg::addr_t d_addr_i,
    input  mem_refill_pkg::line_t d_wline_i,
    output logic                  d_ack_o,
    output mem_refill_pkg::line_t d_line_o,

    // burst memory
    output mem_refill_pkg::addr_t bmem_addr_o,
    output logic                  bmem_read_o,
    output logic                  bmem_write_o,
    output mem_refill_pkg::beat_t bmem_wdata_o,
    input  logic                  bmem_ready_i,
    input  mem_refill_pkg::beat_t bmem_rdata_i,
    input  logic                  bmem_rvalid_i
);

    line_xfer_if rd_xfer ();  // arbiter <-> assembler
    line_xfer_if wr_xfer ();  // arbiter <-> serializer

    refill_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_req_i      (i_req_i),
        .i_addr_i     (i_addr_i),
        .i_ack_o      (i_ack_o),
        .i_line_o     (i_line_o),
        .d_req_i      (d_req_i),
        .d_we_i       (d_we_i),
        .d_addr_i     (d_addr_i),
        .d_wline_i    (d_wline_i),
        .d_ack_o      (d_ack_o),
        .d_line_o     (d_line_o),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_read_o  (bmem_read_o),
        .bmem_ready_i (bmem_ready_i),
        .rd_xfer      (rd_xfer.master),
        .wr_xfer      (wr_xfer.master)
    );

    burst_assembler u_assembler (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .xfer          (rd_xfer.engine)
    );

    burst_serializer u_serializer (
        .clk          (clk),
        .rst          (rst),
        .bmem_ready_i (bmem_ready_i),
        .bmem_write_o (bmem_write_o),
        .bmem_wdata_o (bmem_wdata_o),
        .xfer         (wr_xfer.engine)
    );

endmodule : mem_refill_top

`default_nettype wire

// ==== tb/refill_checker.sv ====
`default_nettype none

module refill_checker #(
    parameter mem_refill_pkg::addr_t WIN_BASE = '0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_req_i,
    input  logic                  i_ack_i,
    input  mem_refill_pkg::addr_t i_addr_i,
    input  mem_refill_pkg::line_t i_line_i,
    input  logic                  d_req_i,
    input  logic                  d_ack_i,
    input  logic                  d_we_i,
    input  mem_refill_pkg::addr_t d_addr_i,
    input  mem_refill_pkg::line_t d_wline_i,
    input  mem_refill_pkg::line_t d_line_i,
    input  mem_refill_pkg::addr_t bmem_addr_i,
    input  logic                  bmem_read_i,
    input  logic                  bmem_write_i,
    input  logic                  bmem_ready_i,
    input  mem_refill_pkg::beat_t bmem_wdata_i,
    output int                    test_count_o,
    output int                    error_count_o
);
    import mem_refill_pkg::*;

    line_t ref_mem [16];  // what memory should hold
    logic  prev_i_req, prev_i_ack, prev_d_req, prev_d_ack;
    logic  i_served, d_served;
    logic  d_first;       // both requests rose together
    logic  idle_checked;
    int    wr_beats;
    int    test_errs;
    addr_t last_rd_addr;

    function automatic addr_t line_base(input addr_t a);
        return a & ~addr_t'(LINE_BITS / 8 - 1);
    endfunction

    task automatic log_error(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        error_count_o++;
        test_errs++;
    endtask

    task automatic close_test(input string what, input addr_t a);
        test_count_o++;
        $display("test %0d %s at 0x%08h: %s", test_count_o, what, a,
                 (test_errs == 0) ? "ok" : "mismatch");
        test_errs = 0;
    endtask

    task automatic check_read(input string who, input addr_t a, input line_t got);
        if (last_rd_addr != line_base(a))
            log_error($sformatf("%s read went to 0x%08h", who, last_rd_addr));
        if (got !== ref_mem[a[LINE_OFFSET_BITS +: 4]])
            log_error($sformatf("%s line %h, expected %h", who, got,
                                ref_mem[a[LINE_OFFSET_BITS +: 4]]));
        close_test({who, " read"}, a);
    endtask

    // each beat holds its own byte address and the complement
    initial begin : ref_fill
        addr_t a;
        for (int l = 0; l < 16; l++) begin
            for (int b = 0; b < BEATS_PER_LINE; b++) begin
                a = WIN_BASE + addr_t'(l * (LINE_BITS / 8) + b * (BEAT_BITS / 8));
                ref_mem[l][b*BEAT_BITS +: BEAT_BITS] = {a, ~a};
            end
        end
    end

    // sampled mid-cycle where inputs and outputs are settled
    always @(negedge clk) begin
        if (rst) begin
            {prev_i_req, prev_i_ack, prev_d_req, prev_d_ack} = '0;
            {i_served, d_served, d_first, idle_checked} = '0;
            wr_beats  = 0;
            test_errs = 0;
        end else begin
            if (!idle_checked) begin
                idle_checked = 1'b1;
                if (i_ack_i || d_ack_i || bmem_read_i || bmem_write_i)
                    log_error("outputs not idle after reset");
                close_test("reset state", '0);
            end
            if (bmem_read_i) begin
                if (bmem_addr_i[LINE_OFFSET_BITS-1:0] != '0)
                    log_error($sformatf("bmem_addr 0x%08h not aligned", bmem_addr_i));
                last_rd_addr = bmem_addr_i;
            end
            if (bmem_write_i && bmem_ready_i) begin  // beat taken at next edge
                if (wr_beats >= BEATS_PER_LINE)
                    log_error("more than four write beats");
                else if (bmem_wdata_i !== d_wline_i[wr_beats*BEAT_BITS +: BEAT_BITS])
                    log_error($sformatf("write beat %0d is %h", wr_beats, bmem_wdata_i));
                if (bmem_addr_i != line_base(d_addr_i))
                    log_error($sformatf("write went to 0x%08h", bmem_addr_i));
                wr_beats++;
            end
            if (i_req_i && d_req_i && !prev_i_req && !prev_d_req)
                d_first = 1'b1;
            if (i_ack_i && !prev_i_ack) begin
                if (d_first)
                    log_error("instruction ack rose before the data ack");
                if (!i_req_i || i_served)
                    log_error("instruction ack without a pending request");
                i_served = 1'b1;
                check_read("instruction", i_addr_i, i_line_i);
            end
            if (d_ack_i && !prev_d_ack) begin
                d_first = 1'b0;
                if (!d_req_i || d_served)
                    log_error("data ack without a pending request");
                d_served = 1'b1;
                if (d_we_i) begin
                    if (wr_beats != BEATS_PER_LINE)
                        log_error($sformatf("write sent %0d beats", wr_beats));
                    ref_mem[d_addr_i[LINE_OFFSET_BITS +: 4]] = d_wline_i;
                    close_test("data write", d_addr_i);
                end else begin
                    check_read("data", d_addr_i, d_line_i);
                end
                wr_beats = 0;
            end
            // ack must drop exactly one cycle after req
            if (prev_i_ack && (prev_i_req != i_ack_i))
                log_error("i_ack_o did not fall one cycle after i_req_i");
            if (prev_d_ack && (prev_d_req != d_ack_i))
                log_error("d_ack_o did not fall one cycle after d_req_i");
            if (!i_req_i)
                i_served = 1'b0;
            if (!d_req_i)
                d_served = 1'b0;
            {prev_i_req, prev_i_ack, prev_d_req, prev_d_ack} = {i_req_i, i_ack_i, d_req_i, d_ack_i};
        end
    end

endmodule : refill_checker

`default_nettype wire

// ==== tb/tb_mem_refill.sv ====
`default_nettype none

module tb_mem_refill;
    import mem_refill_pkg::*;

    localparam int          NUM_TESTS        = 40;
    localparam int          REQ_WORST_CYCLES = 32;  // slowest transfer plus handshake
    localparam int          CYCLE_LIMIT      = NUM_TESTS * 2 * REQ_WORST_CYCLES + 20;
    localparam int          DRV_DLY          = 2;
    localparam addr_t       WIN_BASE         = 32'h0004_0000;
    localparam logic [31:0] LFSR_SEED        = 32'h8953_8653;

    logic        clk, rst;
    logic        i_req_i, i_ack_o, d_req_i, d_we_i, d_ack_o;
    addr_t       i_addr_i, d_addr_i, bmem_addr_o;
    line_t       i_line_o, d_line_o, d_wline_i;
    logic        bmem_read_o, bmem_write_o, bmem_ready_i, bmem_rvalid_i;
    beat_t       bmem_wdata_o, bmem_rdata_i;
    int          test_count, error_count, cycles;
    line_t       mem_q [16];           // burst memory model
    logic [31:0] drv_lfsr, mem_lfsr;   // separate streams per process

    mem_refill_top UUT (.*);

    refill_checker #(.WIN_BASE(WIN_BASE)) u_checker (
        .clk           (clk),
        .rst           (rst),
        .i_req_i       (i_req_i),
        .i_ack_i       (i_ack_o),
        .i_addr_i      (i_addr_i),
        .i_line_i      (i_line_o),
        .d_req_i       (d_req_i),
        .d_ack_i       (d_ack_o),
        .d_we_i        (d_we_i),
        .d_addr_i      (d_addr_i),
        .d_wline_i     (d_wline_i),
        .d_line_i      (d_line_o),
        .bmem_addr_i   (bmem_addr_o),
        .bmem_read_i   (bmem_read_o),
        .bmem_write_i  (bmem_write_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_wdata_i  (bmem_wdata_o),
        .test_count_o  (test_count),
        .error_count_o (error_count)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++) begin
            state = lfsr_next(state);
            val   = {val[30:0], state[0]};
        end
    endtask

    // four-phase handshake on one or both ports
    task automatic run_request(input logic want_i, input logic want_d, input logic we,
                               input addr_t ia, input addr_t da, input line_t wl);
        logic i_left, d_left, i_ack_s, d_ack_s;
        @(posedge clk);
        #DRV_DLY;
        {i_req_i, d_req_i, d_we_i} = {want_i, want_d, we};
        i_addr_i  = ia;
        d_addr_i  = da;
        d_wline_i = wl;
        {i_left, d_left} = {want_i, want_d};
        while (i_left || d_left) begin
            @(negedge clk);
            {i_ack_s, d_ack_s} = {i_ack_o, d_ack_o};
            @(posedge clk);
            #DRV_DLY;
            if (i_req_i && i_ack_s)
                i_req_i = 1'b0;
            else if (!i_req_i && !i_ack_s)
                i_left = 1'b0;
            if (d_req_i && d_ack_s)
                d_req_i = 1'b0;
            else if (!d_req_i && !d_ack_s)
                d_left = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : stimulus
        logic [31:0] v;
        logic [1:0]  kind;
        addr_t       ia, da;
        line_t       wl;
        rst = 1'b1;
        {i_req_i, d_req_i, d_we_i} = '0;
        {i_addr_i, d_addr_i, d_wline_i} = '0;
        drv_lfsr = LFSR_SEED;
        repeat (3) @(posedge clk);
        #DRV_DLY;
        rst = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            draw_bits(drv_lfsr, 2, v);
            kind = v[1:0];
            draw_bits(drv_lfsr, 9, v);  // 16 lines, any byte offset
            ia = WIN_BASE | addr_t'(v[8:0]);
            draw_bits(drv_lfsr, 9, v);
            da = WIN_BASE | addr_t'(v[8:0]);
            for (int k = 0; k < LINE_BITS / 32; k++) begin
                draw_bits(drv_lfsr, 32, v);
                wl[k*32 +: 32] = v;
            end
            draw_bits(drv_lfsr, 1, v);
            case (kind)
                2'd0: run_request(1'b1, 1'b0, 1'b0, ia, da, wl);
                2'd1: run_request(1'b0, 1'b1, 1'b0, ia, da, wl);
                2'd2: begin
                    run_request(1'b0, 1'b1, 1'b1, ia, da, wl);
                    run_request(1'b1, 1'b0, 1'b0, da, da, wl);  // read it back
                end
                default: run_request(1'b1, 1'b1, v[0], ia, da, wl);
            endcase
        end
        repeat (4) @(posedge clk);
        $display("tests run: %0d, errors: %0d", test_count, error_count);
        if (error_count == 0 && test_count > NUM_TESTS)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    initial begin : memory_model
        logic        rd_acc, wr_acc, rd_busy;
        logic [3:0]  wr_idx, rd_idx;
        logic [31:0] v;
        addr_t       a;
        beat_t       wdata_s;
        int          wr_beat, rd_beat, rd_wait, stalls;
        {bmem_ready_i, bmem_rvalid_i, rd_busy} = '0;
        bmem_rdata_i = '0;
        {wr_beat, rd_beat, rd_wait, stalls} = '0;
        mem_lfsr = LFSR_SEED;
        for (int l = 0; l < 16; l++) begin
            for (int b = 0; b < BEATS_PER_LINE; b++) begin
                a = WIN_BASE + addr_t'(l * (LINE_BITS / 8) + b * (BEAT_BITS / 8));
                mem_q[l][b*BEAT_BITS +: BEAT_BITS] = {a, ~a};
            end
        end
        forever begin
            @(negedge clk);
            rd_acc  = bmem_read_o && bmem_ready_i;
            wr_acc  = bmem_write_o && bmem_ready_i;
            wr_idx  = bmem_addr_o[LINE_OFFSET_BITS +: 4];
            wdata_s = bmem_wdata_o;
            @(posedge clk);
            #DRV_DLY;
            bmem_rvalid_i = 1'b0;
            if (rst) begin
                {rd_busy, bmem_ready_i} = '0;
                wr_beat = 0;
            end else begin
                if (wr_acc) begin
                    mem_q[wr_idx][wr_beat*BEAT_BITS +: BEAT_BITS] = wdata_s;
                    wr_beat = (wr_beat + 1) % BEATS_PER_LINE;
                end
                if (rd_busy) begin
                    draw_bits(mem_lfsr, 2, v);
                    if (v[1:0] != 2'b00 || rd_wait >= 2) begin  // gap of at most two
                        bmem_rvalid_i = 1'b1;
                        bmem_rdata_i  = mem_q[rd_idx][rd_beat*BEAT_BITS +: BEAT_BITS];
                        rd_busy = (rd_beat != BEATS_PER_LINE - 1);
                        rd_beat++;
                        rd_wait = 0;
                    end else begin
                        rd_wait++;
                    end
                end
                if (rd_acc) begin
                    rd_busy = 1'b1;
                    rd_idx  = wr_idx;  // same address bus
                    rd_beat = 0;
                end
                draw_bits(mem_lfsr, 2, v);
                bmem_ready_i = (v[1:0] != 2'b00) || stalls >= 2;
                stalls = bmem_ready_i ? 0 : stalls + 1;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_mem_refill

`default_nettype wire

// ==== mem_refill.f ====
src/mem_refill_pkg.sv
src/line_xfer_if.sv
src/burst_assembler.sv
src/burst_serializer.sv
src/refill_arbiter.sv
src/mem_refill_top.sv
tb/refill_checker.sv
tb/tb_mem_refill.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the mem_refill testbench with Verilator and runs it

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
    --top-module tb_mem_refill \
    -Mdir "$OBJ" -o sim_mem_refill \
    -f mem_refill.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"$OBJ"/sim_mem_refill > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
